// File: sim.f
+incdir+rtl
+incdir+sim
rtl/executePkg.sv
rtl/instrDecoder.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/flagRegister.sv
rtl/executeUnit.sv
sim/executeUnitTb.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := executeUnitTb
FILELIST  := sim.f
BUILDDIR  := obj_dir
LOG       := sim.log
PASS_TEXT := ** PASS **
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rtl/alu_cfg.svh sim/aluRefModel.svh

.PHONY: all compile run clean

all: run

compile: $(BUILDDIR)/V$(TOP)

$(BUILDDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

# Result is decided by the log contents
run: compile
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: sim/aluRefModel.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Functions MOV1 through SHR have a destination
function automatic logic writesRegister(input logic [3:0] code);
    return (code >= MOV1) && (code <= SHR);
endfunction

function automatic logic [`DATA_WIDTH-1:0] aluResult(
    input logic [3:0]             code,
    input logic [`DATA_WIDTH-1:0] a,
    input logic [`DATA_WIDTH-1:0] b
);
    case (code)
        MOV1:    return a;
        MOV2:    return b;
        NOT:     return ~a;
        INC:     return a + 16'd1;
        DEC:     return a - 16'd1;
        ADD:     return a + b;
        SUB:     return a - b;
        AND:     return a & b;
        OR:      return a | b;
        SHL:     return (b >= `DATA_WIDTH) ? '0 : a << b;  // All bits gone at 16
        SHR:     return (b >= `DATA_WIDTH) ? '0 : a >> b;
        default: return '0;                                // NOP, SETC, CLRC, 14, 15
    endcase
endfunction

function automatic logic carryOut(
    input logic [3:0]             code,
    input logic [`DATA_WIDTH-1:0] a,
    input logic [`DATA_WIDTH-1:0] b
);
    int unsigned ua;
    int unsigned ub;
    ua = a;
    ub = b;
    case (code)
        SETC:    return 1'b1;
        INC:     return (ua + 1) > 32'hFFFF;   // Sum needs a 17th bit
        ADD:     return (ua + ub) > 32'hFFFF;
        DEC:     return ua < 1;                // Borrow only from zero
        SUB:     return ub > ua;               // Subtrahend larger
        SHL:     return (ub == 0 || ub > 16) ? 1'b0 : a[4'(16 - ub)];
        SHR:     return (ub == 0 || ub > 16) ? 1'b0 : a[4'(ub - 1)];
        default: return 1'b0;                  // CLRC and the rest
    endcase
endfunction

function automatic logic [`DATA_WIDTH-1:0] updatedFlags(
    input logic [`DATA_WIDTH-1:0] oldFlags,
    input logic [3:0]             code,
    input logic [`DATA_WIDTH-1:0] a,
    input logic [`DATA_WIDTH-1:0] b
);
    logic [`DATA_WIDTH-1:0] res;
    logic [`DATA_WIDTH-1:0] nf;
    res = aluResult(code, a, b);
    nf  = oldFlags;
    case (code)
        MOV1, MOV2, NOT, AND, OR: begin
            nf[FLAG_ZERO] = (res == '0);
            nf[FLAG_SIGN] = res[`DATA_WIDTH-1];  // Carry kept
        end
        INC, DEC, ADD, SUB, SHL, SHR: begin
            nf[FLAG_ZERO]  = (res == '0);
            nf[FLAG_SIGN]  = res[`DATA_WIDTH-1];
            nf[FLAG_CARRY] = carryOut(code, a, b);
        end
        SETC, CLRC: nf[FLAG_CARRY] = carryOut(code, a, b);
        default:    nf = oldFlags;
    endcase
    return nf;
endfunction

`endif

// File: sim/executeUnitTb.sv
`timescale 1ns/10ps

`include "alu_cfg.svh"

module executeUnitTb;
    import executePkg::*;

    `include "aluRefModel.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int ARITH_COUNT  = 200;  // Random arithmetic instructions
    localparam int SHIFT_COUNT  = 8;    // Random shift amounts
    // Upper cycle bound of each test
    localparam int RESET_TEST_CYCLES = 2 * `REG_COUNT + RESET_CYCLES + 8;
    localparam int HOST_TEST_CYCLES  = 3 * `REG_COUNT + 6;
    localparam int ARITH_TEST_CYCLES = 7 + `REG_COUNT + ARITH_COUNT + 4;
    localparam int LOGIC_TEST_CYCLES = 3 + 11 + 4;
    localparam int SHIFT_TEST_CYCLES = 4 * (5 + SHIFT_COUNT) + 4;
    localparam int DEP_TEST_CYCLES   = 2 + 6 + 3 + 1 + 4;
    localparam int MARGIN_CYCLES     = 100;
    localparam int TIMEOUT_NS = CLK_PERIOD * (RESET_CYCLES + RESET_TEST_CYCLES
        + HOST_TEST_CYCLES + ARITH_TEST_CYCLES + LOGIC_TEST_CYCLES
        + SHIFT_TEST_CYCLES + DEP_TEST_CYCLES + MARGIN_CYCLES);

    logic                       clk;
    logic                       reset;
    logic [`DATA_WIDTH-1:0]     instr;
    logic                       instrValid;
    logic                       hostWrite;
    logic [`REG_ADDR_WIDTH-1:0] hostAddr;
    logic [`DATA_WIDTH-1:0]     hostData;
    logic [`DATA_WIDTH-1:0]     result;
    logic [`DATA_WIDTH-1:0]     flags;

    logic [`DATA_WIDTH-1:0] expResult;     // Driven alongside instr
    logic [`DATA_WIDTH-1:0] expFlags;      // Flags after this instruction
    logic                   flagsPending;  // Flag check due this edge
    logic [`DATA_WIDTH-1:0] flagsWant;
    logic [`DATA_WIDTH-1:0] shadowRegs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] shadowFlags;
    int                     errorCount;
    int                     testStartErrors;
    int                     testsPassed;
    int                     testsFailed;
    string                  testName;

    executeUnit i_executeUnit (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .hostWrite  (hostWrite),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .result     (result),
        .flags      (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Flags land one edge after the instruction cycle
    always @(posedge clk) begin
        flagsPending <= instrValid;
        flagsWant    <= expFlags;
    end

    resultCheck: assert property (@(posedge clk) disable iff (reset)
        instrValid |-> (result == expResult))
    else begin
        errorCount++;
        $display("mismatch result: got %h expected %h", $sampled(result), $sampled(expResult));
    end

    flagsCheck: assert property (@(posedge clk) disable iff (reset)
        flagsPending |-> (flags == flagsWant))
    else begin
        errorCount++;
        $display("mismatch flags: got %h expected %h", $sampled(flags), $sampled(flagsWant));
    end

    resetFlagsCheck: assert property (@(posedge clk) $fell(reset) |-> (flags == '0))
    else begin
        errorCount++;
        $display("mismatch flags after reset: got %h expected %h", $sampled(flags), 16'h0000);
    end

    upperFlagsCheck: assert property (@(posedge clk) disable iff (reset)
        flags[`DATA_WIDTH-1:3] == '0)
    else begin
        errorCount++;
        $display("mismatch flags upper bits: got %h expected %h", $sampled(flags), 16'h0000);
    end

    task automatic hostLoad(input logic [2:0] addr, input logic [`DATA_WIDTH-1:0] data);
        @(posedge clk);
        instrValid <= 1'b0;
        hostWrite  <= 1'b1;
        hostAddr   <= addr;
        hostData   <= data;
        shadowRegs[addr] = data;
    endtask

    task automatic issueInstr(
        input logic [3:0] code,
        input logic [2:0] rd,
        input logic [2:0] rs1,
        input logic [2:0] rs2
    );
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] res;
        logic [`DATA_WIDTH-1:0] nf;
        @(posedge clk);
        a   = shadowRegs[rs1];
        b   = shadowRegs[rs2];
        res = aluResult(code, a, b);
        nf  = updatedFlags(shadowFlags, code, a, b);
        instr      <= {code, rd, rs1, rs2, 3'($urandom)};  // Low bits are don't care
        instrValid <= 1'b1;
        hostWrite  <= 1'b0;
        expResult  <= res;
        expFlags   <= nf;
        if (writesRegister(code)) begin
            shadowRegs[rd] = res;
        end
        shadowFlags = nf;
    endtask

    // Host write to the instruction's destination in the same cycle is lost
    task automatic issueWithHostWrite(
        input logic [3:0]             code,
        input logic [2:0]             rd,
        input logic [2:0]             rs1,
        input logic [`DATA_WIDTH-1:0] data
    );
        issueInstr(code, rd, rs1, 3'd0);
        hostWrite <= 1'b1;
        hostAddr  <= rd;
        hostData  <= data;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        instrValid <= 1'b0;
        hostWrite  <= 1'b0;
    endtask

    // Mid-run reset with registers and flags left nonzero
    task automatic applyReset();
        idleCycle();
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        shadowFlags = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadowRegs[r] = '0;
        end
    endtask

    task automatic shiftPair(input logic [`DATA_WIDTH-1:0] amount);
        hostLoad(3'd1, 16'($urandom) | 16'h8001);  // Both end bits set
        hostLoad(3'd2, amount);
        issueInstr(SHL, 3'd3, 3'd1, 3'd2);
        issueInstr(SHR, 3'd4, 3'd1, 3'd2);
    endtask

    function automatic logic [3:0] randomArithOp();
        case ($urandom_range(0, 3))
            0:       return INC;
            1:       return DEC;
            2:       return ADD;
            default: return SUB;
        endcase
    endfunction

    task automatic beginTest(input string name);
        testName        = name;
        testStartErrors = errorCount;
    endtask

    task automatic endTest();
        int newErrors;
        idleCycle();
        repeat (3) @(posedge clk);  // Last flag check is two edges out
        newErrors = errorCount - testStartErrors;
        if (newErrors == 0) begin
            testsPassed++;
            $display("Test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", testName, newErrors);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'hada6));
        reset        = 1'b1;
        instr        = '0;
        instrValid   = 1'b0;
        hostWrite    = 1'b0;
        hostAddr     = '0;
        hostData     = '0;
        expResult    = '0;
        expFlags     = '0;
        flagsPending = 1'b0;
        flagsWant    = '0;
        shadowFlags  = '0;
        errorCount   = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadowRegs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        beginTest("reset state");
        for (int r = 0; r < `REG_COUNT; r++) begin
            hostLoad(3'(r), 16'($urandom) | 16'h0001);  // Nonzero before reset
        end
        issueInstr(SETC, 3'd0, 3'd0, 3'd0);
        issueInstr(NOT, 3'd1, 3'd1, 3'd0);
        applyReset();
        for (int r = 0; r < `REG_COUNT; r++) begin
            issueInstr(MOV1, 3'(r), 3'(r), 3'd0);  // Every register reads zero
        end
        endTest();

        beginTest("host preload");
        for (int r = 0; r < `REG_COUNT; r++) begin
            hostLoad(3'(r), 16'($urandom));
        end
        for (int r = 0; r < `REG_COUNT; r++) begin
            issueInstr(MOV1, 3'(r), 3'(r), 3'd0);
        end
        for (int r = 0; r < `REG_COUNT; r++) begin
            issueInstr(MOV2, 3'(r), 3'd0, 3'(r));
        end
        issueWithHostWrite(MOV1, 3'd2, 3'd5, 16'hDEAD);
        issueInstr(MOV1, 3'd2, 3'd2, 3'd0);  // Holds r5 rather than host data
        endTest();

        beginTest("arithmetic");
        hostLoad(3'd1, 16'hFFFF);
        hostLoad(3'd4, 16'h0001);
        hostLoad(3'd5, 16'h0000);
        issueInstr(INC, 3'd2, 3'd1, 3'd0);  // FFFF + 1 wraps with carry
        issueInstr(ADD, 3'd3, 3'd1, 3'd4);
        issueInstr(DEC, 3'd6, 3'd5, 3'd0);  // 0 - 1 borrows
        issueInstr(SUB, 3'd7, 3'd5, 3'd4);
        for (int r = 0; r < `REG_COUNT; r++) begin
            hostLoad(3'(r), 16'($urandom));
        end
        for (int i = 0; i < ARITH_COUNT; i++) begin
            issueInstr(randomArithOp(), 3'($urandom), 3'($urandom), 3'($urandom));
        end
        endTest();

        beginTest("logic and carry");
        hostLoad(3'd1, 16'($urandom));
        hostLoad(3'd2, 16'($urandom));
        hostLoad(3'd3, 16'h0000);
        issueInstr(SETC, 3'd7, 3'd1, 3'd2);  // rd field must not be written
        issueInstr(NOT, 3'd4, 3'd1, 3'd0);
        issueInstr(AND, 3'd5, 3'd1, 3'd2);
        issueInstr(OR, 3'd6, 3'd1, 3'd2);
        issueInstr(CLRC, 3'd0, 3'd1, 3'd2);
        issueInstr(NOT, 3'd4, 3'd3, 3'd0);   // FFFF sets sign
        issueInstr(AND, 3'd5, 3'd1, 3'd3);   // Zero result
        issueInstr(OR, 3'd6, 3'd3, 3'd3);
        issueInstr(SETC, 3'd1, 3'd0, 3'd0);
        issueInstr(MOV1, 3'd7, 3'd7, 3'd0);  // r7 untouched by SETC
        issueInstr(MOV2, 3'd0, 3'd0, 3'd0);  // r0 untouched by CLRC
        endTest();

        beginTest("shifts");
        shiftPair(16'd0);
        shiftPair(16'd1);
        shiftPair(16'd15);
        shiftPair(16'd16);
        shiftPair(16'd17);
        for (int i = 0; i < SHIFT_COUNT; i++) begin
            shiftPair((i % 2 == 0) ? 16'($urandom_range(0, 20)) : 16'($urandom));
        end
        endTest();

        beginTest("dependent and nop");
        hostLoad(3'd1, 16'($urandom));
        hostLoad(3'd2, 16'($urandom) & 16'h000F);  // Small shift amount
        issueInstr(ADD, 3'd3, 3'd1, 3'd2);
        issueInstr(ADD, 3'd3, 3'd3, 3'd2);         // Uses r3 from the cycle before
        issueInstr(SUB, 3'd4, 3'd3, 3'd1);
        issueInstr(INC, 3'd4, 3'd4, 3'd0);
        issueInstr(SHL, 3'd5, 3'd4, 3'd2);
        issueInstr(MOV1, 3'd6, 3'd5, 3'd0);
        issueInstr(NOP, 3'd6, 3'd1, 3'd2);
        issueInstr(4'd14, 3'd6, 3'd1, 3'd2);
        issueInstr(4'd15, 3'd6, 3'd1, 3'd2);
        issueInstr(MOV1, 3'd7, 3'd6, 3'd0);        // r6 still from MOV1
        endTest();

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: rtl/executeUnit.sv
`timescale 1ns/10ps

`include "alu_cfg.svh"

module executeUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`DATA_WIDTH-1:0]     instr,
    input  logic                       instrValid,
    input  logic                       hostWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] hostAddr,
    input  logic [`DATA_WIDTH-1:0]     hostData,
    output logic [`DATA_WIDTH-1:0]     result,
    output logic [`DATA_WIDTH-1:0]     flags
);
    import executePkg::*;

    aluFunc                     func;        // Decoded function
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic                       regWrite;    // Already gated by instrValid
    flagClass                   flagUpdate;  // Already gated by instrValid
    logic [`DATA_WIDTH-1:0]     op1;
    logic [`DATA_WIDTH-1:0]     op2;
    logic                       nextZero;
    logic                       nextSign;
    logic                       nextCarry;

    instrDecoder i_instrDecoder (
        .instr      (instr),
        .instrValid (instrValid),
        .func       (func),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .regWrite   (regWrite),
        .flagUpdate (flagUpdate)
    );

    registerFile i_registerFile (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .regWrite  (regWrite),
        .writeData (result),  // ALU result written back
        .hostWrite (hostWrite),
        .hostAddr  (hostAddr),
        .hostData  (hostData),
        .op1       (op1),
        .op2       (op2)
    );

    alu i_alu (
        .op1       (op1),
        .op2       (op2),
        .func      (func),
        .result    (result),
        .nextZero  (nextZero),
        .nextSign  (nextSign),
        .nextCarry (nextCarry)
    );

    flagRegister i_flagRegister (
        .clk        (clk),
        .reset      (reset),
        .flagUpdate (flagUpdate),
        .nextZero   (nextZero),
        .nextSign   (nextSign),
        .nextCarry  (nextCarry),
        .flags      (flags)
    );

endmodule

// File: rtl/flagRegister.sv
`timescale 1ns/10ps

`include "alu_cfg.svh"

module flagRegister (
    input  logic                   clk,
    input  logic                   reset,
    input  executePkg::flagClass   flagUpdate,
    input  logic                   nextZero,
    input  logic                   nextSign,
    input  logic                   nextCarry,
    output logic [`DATA_WIDTH-1:0] flags
);
    import executePkg::*;

    logic zeroBit;
    logic signBit;
    logic carryBit;
    logic loadZs;     // Zero and sign enable
    logic loadCarry;  // Carry enable

    assign loadZs    = (flagUpdate == FLAGS_ZS) || (flagUpdate == FLAGS_ZSC);
    assign loadCarry = (flagUpdate == FLAGS_ZSC) || (flagUpdate == FLAGS_CARRY_ONLY);

    always_ff @(posedge clk) begin
        if (reset) begin
            zeroBit  <= 1'b0;
            signBit  <= 1'b0;
            carryBit <= 1'b0;
        end else begin
            if (loadZs) begin
                zeroBit <= nextZero;
                signBit <= nextSign;
            end
            if (loadCarry) begin
                carryBit <= nextCarry;  // SETC, CLRC or arithmetic
            end
        end
    end

    // Pack into the flag word, upper bits stay zero
    always_comb begin
        flags             = '0;
        flags[FLAG_ZERO]  = zeroBit;
        flags[FLAG_SIGN]  = signBit;
        flags[FLAG_CARRY] = carryBit;
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps

`include "alu_cfg.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] op1,
    input  logic [`DATA_WIDTH-1:0] op2,
    input  executePkg::aluFunc     func,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   nextZero,
    output logic                   nextSign,
    output logic                   nextCarry
);
    import executePkg::*;

    logic [`DATA_WIDTH:0] incSum;   // Carry in top bit
    logic [`DATA_WIDTH:0] decDiff;  // Borrow in top bit
    logic [`DATA_WIDTH:0] addSum;   // Carry in top bit
    logic [`DATA_WIDTH:0] subDiff;  // Borrow in top bit
    logic [`DATA_WIDTH:0] shlWide;  // {carry, result}
    logic [`DATA_WIDTH:0] shrWide;  // {result, carry}

    // 17-bit arithmetic, top bit is carry or borrow
    assign incSum  = {1'b0, op1} + {{`DATA_WIDTH{1'b0}}, 1'b1};
    assign decDiff = {1'b0, op1} - {{`DATA_WIDTH{1'b0}}, 1'b1};
    assign addSum  = {1'b0, op1} + {1'b0, op2};
    assign subDiff = {1'b0, op1} - {1'b0, op2};

    // Shift through a spare bit to catch the last bit out
    // Amount 0 leaves the spare bit at 0, amounts past 16 clear everything
    assign shlWide = {1'b0, op1} << op2;
    assign shrWide = {op1, 1'b0} >> op2;

    always_comb begin
        result    = '0;
        nextCarry = 1'b0;
        case (func)
            NOP: begin
                result    = '0;  // Nothing to do
                nextCarry = 1'b0;
            end
            SETC: begin
                result    = '0;
                nextCarry = 1'b1;  // Candidate carry set
            end
            CLRC: begin
                result    = '0;
                nextCarry = 1'b0;  // Candidate carry clear
            end
            MOV1: begin
                result = op1;
            end
            MOV2: begin
                result = op2;
            end
            NOT: begin
                result = ~op1;
            end
            INC: begin
                result    = incSum[`DATA_WIDTH-1:0];
                nextCarry = incSum[`DATA_WIDTH];    // Wrap from FFFF
            end
            DEC: begin
                result    = decDiff[`DATA_WIDTH-1:0];
                nextCarry = decDiff[`DATA_WIDTH];   // Borrow when op1 is 0
            end
            ADD: begin
                result    = addSum[`DATA_WIDTH-1:0];
                nextCarry = addSum[`DATA_WIDTH];
            end
            SUB: begin
                result    = subDiff[`DATA_WIDTH-1:0];
                nextCarry = subDiff[`DATA_WIDTH];   // op2 > op1
            end
            AND: begin
                result = op1 & op2;
            end
            OR: begin
                result = op1 | op2;
            end
            SHL: begin
                result    = shlWide[`DATA_WIDTH-1:0];
                nextCarry = shlWide[`DATA_WIDTH];   // Last bit out of the top
            end
            SHR: begin
                result    = shrWide[`DATA_WIDTH:1];
                nextCarry = shrWide[0];             // Last bit out of the bottom
            end
            default: begin
                result    = '0;  // Unused codes
                nextCarry = 1'b0;
            end
        endcase
    end

    // Zero and sign follow the result for every class
    assign nextZero = (result == '0);
    assign nextSign = result[`DATA_WIDTH-1];

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/10ps

`include "alu_cfg.svh"

module registerFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       regWrite,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    input  logic                       hostWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] hostAddr,
    input  logic [`DATA_WIDTH-1:0]     hostData,
    output logic [`DATA_WIDTH-1:0]     op1,
    output logic [`DATA_WIDTH-1:0]     op2
);

    logic [`DATA_WIDTH-1:0]     regs [`REG_COUNT];  // Register array
    logic                       wrEn;               // Merged write strobe
    logic [`REG_ADDR_WIDTH-1:0] wrAddr;
    logic [`DATA_WIDTH-1:0]     wrData;

    // Instruction write has priority, host write dropped on collision
    always_comb begin
        wrEn   = regWrite | hostWrite;
        wrAddr = regWrite ? rd : hostAddr;
        wrData = regWrite ? writeData : hostData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;  // All registers start at zero
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads, see last edge's write
    assign op1 = regs[rs1];
    assign op2 = regs[rs2];

endmodule

// File: rtl/instrDecoder.sv
`timescale 1ns/10ps

`include "alu_cfg.svh"

module instrDecoder (
    input  logic [`DATA_WIDTH-1:0]     instr,
    input  logic                       instrValid,
    output executePkg::aluFunc         func,
    output logic [`REG_ADDR_WIDTH-1:0] rd,
    output logic [`REG_ADDR_WIDTH-1:0] rs1,
    output logic [`REG_ADDR_WIDTH-1:0] rs2,
    output logic                       regWrite,
    output executePkg::flagClass       flagUpdate
);
    import executePkg::*;

    logic [3:0] funcCode;      // Raw function field
    logic       writesReg;     // Function has a destination
    flagClass   decodedClass;  // Flag class before validity gating

    assign funcCode = instr[15:12];
    assign rd       = instr[11:9];   // Destination
    assign rs1      = instr[8:6];    // First source
    assign rs2      = instr[5:3];    // Second source

    // Codes 14 and 15 fold onto NOP
    assign func = (funcCode > 4'(SHR)) ? NOP : aluFunc'(funcCode);

    always_comb begin
        writesReg    = 1'b0;
        decodedClass = FLAGS_NONE;
        case (func)
            SETC, CLRC: begin
                decodedClass = FLAGS_CARRY_ONLY;  // No register write
            end
            MOV1, MOV2, NOT, AND, OR: begin
                writesReg    = 1'b1;
                decodedClass = FLAGS_ZS;          // Logic ops keep carry
            end
            INC, DEC, ADD, SUB, SHL, SHR: begin
                writesReg    = 1'b1;
                decodedClass = FLAGS_ZSC;         // Arithmetic and shifts
            end
            default: begin
                writesReg    = 1'b0;              // NOP
                decodedClass = FLAGS_NONE;
            end
        endcase
    end

    // Only valid instructions reach state
    assign regWrite   = instrValid & writesReg;
    assign flagUpdate = instrValid ? decodedClass : FLAGS_NONE;

endmodule

// File: rtl/executePkg.sv
package executePkg;

    // Function codes, bits 15..12 of the instruction
    typedef enum logic [3:0] {
        NOP  = 4'd0,   // No operation
        SETC = 4'd1,   // Carry to 1
        CLRC = 4'd2,   // Carry to 0
        MOV1 = 4'd3,   // Pass op1
        MOV2 = 4'd4,   // Pass op2
        NOT  = 4'd5,   // Invert op1
        INC  = 4'd6,   // op1 + 1
        DEC  = 4'd7,   // op1 - 1
        ADD  = 4'd8,   // op1 + op2
        SUB  = 4'd9,   // op1 - op2
        AND  = 4'd10,  // Bitwise and
        OR   = 4'd11,  // Bitwise or
        SHL  = 4'd12,  // op1 << op2
        SHR  = 4'd13   // op1 >> op2
    } aluFunc;

    // Bit positions in the flag word
    localparam int unsigned FLAG_ZERO  = 0;
    localparam int unsigned FLAG_SIGN  = 1;
    localparam int unsigned FLAG_CARRY = 2;

    // Which flag bits an instruction loads
    typedef enum logic [1:0] {
        FLAGS_NONE       = 2'd0,  // Flags untouched
        FLAGS_ZS         = 2'd1,  // Zero and sign only
        FLAGS_ZSC        = 2'd2,  // Zero, sign and carry
        FLAGS_CARRY_ONLY = 2'd3   // SETC / CLRC
    } flagClass;

endpackage

// File: rtl/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Datapath width, shared by operands, results and flag word
`define DATA_WIDTH 16

// Register file geometry
`define REG_COUNT 8
`define REG_ADDR_WIDTH 3

`endif
